// File: src/img_core_pkg.sv
`default_nettype none

package img_core_pkg;

    // --------------------------------------------------
    // image geometry
    // --------------------------------------------------
    localparam int IMG_W   = 8;
    localparam int IMG_H   = 8;
    localparam int IMG_C   = 32;
    localparam int IMG_PIX = IMG_W * IMG_H * IMG_C;

    // channel c sits in bank c mod 4
    localparam int BANK_COUNT = 4;
    localparam int BANK_WORDS = IMG_PIX / BANK_COUNT;

    // datapath widths
    localparam int PIX_W = 8;
    localparam int OUT_W = 14;
    localparam int ACC_W = 18;

    // largest window origin on either axis
    localparam int ORG_MAX = 6;

    // conv result is (sum + 8) >> 4
    localparam logic [ACC_W-1:0] ROUND_BIAS = 8;
    localparam int ROUND_SHIFT = 4;

    // --------------------------------------------------
    // opcodes
    // --------------------------------------------------
    localparam logic [3:0] OP_LOAD    = 4'd0;
    localparam logic [3:0] OP_ORG_R   = 4'd1;
    localparam logic [3:0] OP_ORG_L   = 4'd2;
    localparam logic [3:0] OP_ORG_U   = 4'd3;
    localparam logic [3:0] OP_ORG_D   = 4'd4;
    localparam logic [3:0] OP_SCALE_D = 4'd5;
    localparam logic [3:0] OP_SCALE_U = 4'd6;
    localparam logic [3:0] OP_DISPLAY = 4'd7;
    localparam logic [3:0] OP_CONV    = 4'd8;

    typedef enum logic [1:0] {
        DEPTH_8  = 2'd0,
        DEPTH_16 = 2'd1,
        DEPTH_32 = 2'd2
    } depth_e;

    // gaussian kernel, row major over ky then kx
    localparam logic [2:0] GAUSS_W [9] = '{
        3'd1, 3'd2, 3'd1,
        3'd2, 3'd4, 3'd2,
        3'd1, 3'd2, 3'd1
    };

    // --------------------------------------------------
    // bundles
    // --------------------------------------------------
    typedef struct packed {
        logic [$clog2(IMG_W)-1:0] origin_x;
        logic [$clog2(IMG_H)-1:0] origin_y;
        depth_e                   depth;
    } view_t;

    typedef struct packed {
        logic                          en;
        logic                          we;
        logic [$clog2(BANK_COUNT)-1:0] bank;
        logic [$clog2(BANK_WORDS)-1:0] addr;
        logic [PIX_W-1:0]              wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    valid;
        logic signed [OUT_W-1:0] data;
    } pix_out_t;

    // number of active channels for a depth code
    function automatic logic [5:0] depth_chans(depth_e d);
        case (d)
            DEPTH_8:  return 6'd8;
            DEPTH_16: return 6'd16;
            default:  return 6'd32;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: src/img_bank_mem.sv
`timescale 1ns/1ps
`default_nettype none

module img_bank_mem (
    input  wire                                  i_clk,
    input  wire img_core_pkg::mem_req_t          i_req,
    output logic [img_core_pkg::PIX_W-1:0]       o_rdata
);

    // per bank read data, muxed by the bank of the last read
    wire  [img_core_pkg::PIX_W-1:0]              bank_rd [img_core_pkg::BANK_COUNT];
    logic [$clog2(img_core_pkg::BANK_COUNT)-1:0] rd_bank_q;

    // --------------------------------------------------
    // banks
    // --------------------------------------------------
    for (genvar gi = 0; gi < img_core_pkg::BANK_COUNT; gi++) begin : gen_bank
        logic [img_core_pkg::PIX_W-1:0] mem [img_core_pkg::BANK_WORDS];
        logic [img_core_pkg::PIX_W-1:0] rd_q;
        logic                           hit;

        // only the addressed bank sees the request
        assign hit = i_req.en && (i_req.bank == gi);

        always_ff @(posedge i_clk) begin
            if (hit) begin
                if (i_req.we) begin
                    mem[i_req.addr] <= i_req.wdata;
                end else begin
                    rd_q <= mem[i_req.addr];
                end
            end
        end

        assign bank_rd[gi] = rd_q;
    end

    // remember which bank answers next cycle
    always_ff @(posedge i_clk) begin
        if (i_req.en && !i_req.we) begin
            rd_bank_q <= i_req.bank;
        end
    end

    assign o_rdata = bank_rd[rd_bank_q];

endmodule

`default_nettype wire

// File: src/img_loader.sv
`timescale 1ns/1ps
`default_nettype none

module img_loader (
    input  wire                                  i_clk,
    input  wire                                  i_rst_n,
    input  wire                                  i_start,
    input  wire                                  i_in_valid,
    input  wire [img_core_pkg::PIX_W-1:0]        i_in_data,
    output logic                                 o_in_ready,
    output img_core_pkg::mem_req_t               o_req,
    output logic                                 o_done
);

    // raster index c*64 + y*8 + x
    logic [$clog2(img_core_pkg::IMG_PIX)-1:0] cnt_q;
    logic                                     active_q;
    logic                                     done_q;
    logic                                     wr;

    assign wr = active_q && i_in_valid;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (i_start) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
            end else if (wr) begin
                cnt_q <= cnt_q + 1'b1;
                // last byte closes the load
                if (cnt_q == img_core_pkg::IMG_PIX - 1) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end
            end
        end
    end

    // bank from c[1:0], word from c[4:2] and the 64 pixel offset
    assign o_req = '{
        en:    wr,
        we:    1'b1,
        bank:  cnt_q[7:6],
        addr:  {cnt_q[10:8], cnt_q[5:0]},
        wdata: i_in_data
    };

    assign o_in_ready = active_q;
    assign o_done     = done_q;

endmodule

`default_nettype wire

// File: src/view_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module view_ctrl (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_op_valid,
    input  wire [3:0]              i_op_mode,
    input  wire                    i_idle,
    output img_core_pkg::view_t    o_view
);

    img_core_pkg::view_t view_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            view_q.origin_x <= '0;
            view_q.origin_y <= '0;
            view_q.depth    <= img_core_pkg::DEPTH_32;
        end else if (i_idle && i_op_valid) begin
            case (i_op_mode)
                // origin moves saturate at 0 and ORG_MAX
                img_core_pkg::OP_ORG_R: begin
                    if (view_q.origin_x < img_core_pkg::ORG_MAX) begin
                        view_q.origin_x <= view_q.origin_x + 3'd1;
                    end
                end
                img_core_pkg::OP_ORG_L: begin
                    if (view_q.origin_x != 3'd0) begin
                        view_q.origin_x <= view_q.origin_x - 3'd1;
                    end
                end
                // up means a smaller row index
                img_core_pkg::OP_ORG_U: begin
                    if (view_q.origin_y != 3'd0) begin
                        view_q.origin_y <= view_q.origin_y - 3'd1;
                    end
                end
                img_core_pkg::OP_ORG_D: begin
                    if (view_q.origin_y < img_core_pkg::ORG_MAX) begin
                        view_q.origin_y <= view_q.origin_y + 3'd1;
                    end
                end
                // depth steps 32 -> 16 -> 8 and back
                img_core_pkg::OP_SCALE_D: begin
                    if (view_q.depth == img_core_pkg::DEPTH_32) begin
                        view_q.depth <= img_core_pkg::DEPTH_16;
                    end else if (view_q.depth == img_core_pkg::DEPTH_16) begin
                        view_q.depth <= img_core_pkg::DEPTH_8;
                    end
                end
                img_core_pkg::OP_SCALE_U: begin
                    if (view_q.depth == img_core_pkg::DEPTH_8) begin
                        view_q.depth <= img_core_pkg::DEPTH_16;
                    end else if (view_q.depth == img_core_pkg::DEPTH_16) begin
                        view_q.depth <= img_core_pkg::DEPTH_32;
                    end
                end
                default: ;
            endcase
        end
    end

    assign o_view = view_q;

endmodule

`default_nettype wire

// File: src/display_stream.sv
`timescale 1ns/1ps
`default_nettype none

module display_stream (
    input  wire                                  i_clk,
    input  wire                                  i_rst_n,
    input  wire                                  i_start,
    input  wire img_core_pkg::view_t             i_view,
    input  wire [img_core_pkg::PIX_W-1:0]        i_rdata,
    output img_core_pkg::mem_req_t               o_req,
    output img_core_pkg::pix_out_t               o_pix,
    output logic                                 o_done
);

    // read side counters
    logic       active_q;
    logic [1:0] pos_q;
    logic [4:0] ch_q;
    logic [5:0] nch;
    logic       ch_last;
    logic       last;
    logic [2:0] x;
    logic [2:0] y;

    // return side, one cycle behind the read
    logic       rvalid_q;
    logic       rlast_q;
    logic       done_q;

    assign nch     = img_core_pkg::depth_chans(i_view.depth);
    assign ch_last = ({1'b0, ch_q} == nch - 6'd1);
    assign last    = active_q && (pos_q == 2'd3) && ch_last;

    // pos bit 0 steps x and bit 1 steps y
    assign x = i_view.origin_x + {2'b00, pos_q[0]};
    assign y = i_view.origin_y + {2'b00, pos_q[1]};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active_q <= 1'b0;
            pos_q    <= '0;
            ch_q     <= '0;
            rvalid_q <= 1'b0;
            rlast_q  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            rvalid_q <= active_q;
            rlast_q  <= last;
            // done lands the cycle after the last pixel
            done_q   <= rvalid_q && rlast_q;
            if (i_start) begin
                active_q <= 1'b1;
                pos_q    <= '0;
                ch_q     <= '0;
            end else if (active_q) begin
                pos_q <= pos_q + 2'd1;
                if (pos_q == 2'd3) begin
                    if (ch_last) begin
                        active_q <= 1'b0;
                    end else begin
                        ch_q <= ch_q + 5'd1;
                    end
                end
            end
        end
    end

    // one read per active cycle
    assign o_req = '{
        en:    active_q,
        we:    1'b0,
        bank:  ch_q[1:0],
        addr:  {ch_q[4:2], y, x},
        wdata: '0
    };

    // zero extended pixel
    assign o_pix = '{
        valid: rvalid_q,
        data:  {{(img_core_pkg::OUT_W - img_core_pkg::PIX_W){1'b0}}, i_rdata}
    };

    assign o_done = done_q;

endmodule

`default_nettype wire

// File: src/gauss_conv.sv
`timescale 1ns/1ps
`default_nettype none

module gauss_conv (
    input  wire                                  i_clk,
    input  wire                                  i_rst_n,
    input  wire                                  i_start,
    input  wire img_core_pkg::view_t             i_view,
    input  wire [img_core_pkg::PIX_W-1:0]        i_rdata,
    output img_core_pkg::mem_req_t               o_req,
    output img_core_pkg::pix_out_t               o_pix,
    output logic                                 o_done
);

    // --------------------------------------------------
    // tap sequencer, kx innermost then ky, channel, pos
    // --------------------------------------------------
    logic       active_q;
    logic [1:0] kx_q;
    logic [1:0] ky_q;
    logic [1:0] pos_q;
    logic [4:0] ch_q;
    logic [5:0] nch;
    logic       ch_last;
    logic       tap_last;
    logic       all_last;

    // tap coordinates offset by one so -1 becomes 0
    logic [3:0] tx;
    logic [3:0] ty;
    logic [3:0] xm;
    logic [3:0] ym;
    logic       in_img;
    logic [3:0] widx;

    // return side
    logic                                tv_q;
    logic                                plast_q;
    logic                                alast_q;
    logic                                done_q;
    logic                                pad_q;
    logic [2:0]                          w_q;
    logic [img_core_pkg::PIX_W+2:0]      prod;
    logic [img_core_pkg::ACC_W-1:0]      acc_q;
    logic [img_core_pkg::ACC_W-1:0]      sum;
    logic [img_core_pkg::ACC_W-1:0]      rnd;

    assign nch      = img_core_pkg::depth_chans(i_view.depth);
    assign ch_last  = ({1'b0, ch_q} == nch - 6'd1);
    assign tap_last = (kx_q == 2'd2) && (ky_q == 2'd2) && ch_last;
    assign all_last = tap_last && (pos_q == 2'd3);

    assign tx = {1'b0, i_view.origin_x} + {3'b000, pos_q[0]} + {2'b00, kx_q};
    assign ty = {1'b0, i_view.origin_y} + {3'b000, pos_q[1]} + {2'b00, ky_q};
    assign xm = tx - 4'd1;
    assign ym = ty - 4'd1;

    // taps outside the image read as zero
    assign in_img = (tx != 4'd0) && (tx <= img_core_pkg::IMG_W)
                 && (ty != 4'd0) && (ty <= img_core_pkg::IMG_H);

    assign widx = {2'b00, ky_q} * 4'd3 + {2'b00, kx_q};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            active_q <= 1'b0;
            kx_q     <= '0;
            ky_q     <= '0;
            pos_q    <= '0;
            ch_q     <= '0;
            tv_q     <= 1'b0;
            plast_q  <= 1'b0;
            alast_q  <= 1'b0;
            done_q   <= 1'b0;
            acc_q    <= '0;
        end else begin
            tv_q    <= active_q;
            plast_q <= tap_last;
            alast_q <= all_last;
            done_q  <= tv_q && plast_q && alast_q;
            // accumulate, then restart after each output pixel
            if (i_start) begin
                acc_q <= '0;
            end else if (tv_q) begin
                acc_q <= plast_q ? '0 : sum;
            end
            if (i_start) begin
                active_q <= 1'b1;
                kx_q     <= '0;
                ky_q     <= '0;
                pos_q    <= '0;
                ch_q     <= '0;
            end else if (active_q) begin
                kx_q <= (kx_q == 2'd2) ? 2'd0 : kx_q + 2'd1;
                if (kx_q == 2'd2) begin
                    ky_q <= (ky_q == 2'd2) ? 2'd0 : ky_q + 2'd1;
                    if (ky_q == 2'd2) begin
                        ch_q <= ch_last ? 5'd0 : ch_q + 5'd1;
                        if (ch_last) begin
                            pos_q <= pos_q + 2'd1;
                            if (pos_q == 2'd3) begin
                                active_q <= 1'b0;
                            end
                        end
                    end
                end
            end
        end
    end

    // weight and pad flag meet the returned byte
    always_ff @(posedge i_clk) begin
        pad_q <= !in_img;
        w_q   <= img_core_pkg::GAUSS_W[widx];
    end

    assign prod = pad_q ? '0 : w_q * i_rdata;
    assign sum  = acc_q + prod;
    assign rnd  = sum + img_core_pkg::ROUND_BIAS;

    // no memory access for padded taps
    assign o_req = '{
        en:    active_q && in_img,
        we:    1'b0,
        bank:  ch_q[1:0],
        addr:  {ch_q[4:2], ym[2:0], xm[2:0]},
        wdata: '0
    };

    assign o_pix = '{
        valid: tv_q && plast_q,
        data:  rnd[img_core_pkg::ROUND_SHIFT +: img_core_pkg::OUT_W]
    };

    assign o_done = done_q;

endmodule

`default_nettype wire

// File: src/img_core.sv
`timescale 1ns/1ps
`default_nettype none

module img_core (
    input  wire                                      i_clk,
    input  wire                                      i_rst_n,
    input  wire                                      i_op_valid,
    input  wire [3:0]                                i_op_mode,
    input  wire                                      i_in_valid,
    input  wire [img_core_pkg::PIX_W-1:0]            i_in_data,
    output logic                                     o_op_ready,
    output logic                                     o_in_ready,
    output logic                                     o_out_valid,
    output logic signed [img_core_pkg::OUT_W-1:0]    o_out_data
);

    typedef enum logic [1:0] {
        ST_RESET,
        ST_READY,
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e     state_q;
    logic [3:0] act_op_q;
    logic       idle;
    logic       go;
    logic       engine_op;
    logic       ld_start;
    logic       ds_start;
    logic       gc_start;
    logic       ld_done;
    logic       ds_done;
    logic       gc_done;
    logic       eng_done;

    img_core_pkg::view_t            view;
    img_core_pkg::mem_req_t         ld_req;
    img_core_pkg::mem_req_t         ds_req;
    img_core_pkg::mem_req_t         gc_req;
    img_core_pkg::mem_req_t         mem_req;
    img_core_pkg::pix_out_t         ds_pix;
    img_core_pkg::pix_out_t         gc_pix;
    img_core_pkg::pix_out_t         pix_sel;
    logic [img_core_pkg::PIX_W-1:0] rdata;

    // --------------------------------------------------
    // opcode decode and control FSM
    // --------------------------------------------------
    assign idle      = (state_q == ST_IDLE);
    assign go        = idle && i_op_valid;
    assign ld_start  = go && (i_op_mode == img_core_pkg::OP_LOAD);
    assign ds_start  = go && (i_op_mode == img_core_pkg::OP_DISPLAY);
    assign gc_start  = go && (i_op_mode == img_core_pkg::OP_CONV);
    assign engine_op = ld_start || ds_start || gc_start;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= ST_RESET;
            act_op_q <= img_core_pkg::OP_LOAD;
        end else begin
            case (state_q)
                ST_RESET: state_q <= ST_READY;
                ST_READY: state_q <= ST_IDLE;
                // view ops and unknown codes only pulse ready
                ST_IDLE: begin
                    if (i_op_valid) begin
                        act_op_q <= i_op_mode;
                        state_q  <= engine_op ? ST_BUSY : ST_READY;
                    end
                end
                ST_BUSY: begin
                    if (eng_done) begin
                        state_q <= ST_READY;
                    end
                end
                default: state_q <= ST_RESET;
            endcase
        end
    end

    assign o_op_ready = (state_q == ST_READY);

    // memory port and output belong to the running engine
    always_comb begin
        case (act_op_q)
            img_core_pkg::OP_LOAD: begin
                mem_req  = ld_req;
                eng_done = ld_done;
                pix_sel  = gc_pix;
            end
            img_core_pkg::OP_DISPLAY: begin
                mem_req  = ds_req;
                eng_done = ds_done;
                pix_sel  = ds_pix;
            end
            default: begin
                mem_req  = gc_req;
                eng_done = gc_done;
                pix_sel  = gc_pix;
            end
        endcase
    end

    // --------------------------------------------------
    // output register
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= pix_sel.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_out_data <= pix_sel.data;
    end

    // --------------------------------------------------
    // submodules
    // --------------------------------------------------
    img_bank_mem u_mem (
        .i_clk   (i_clk),
        .i_req   (mem_req),
        .o_rdata (rdata)
    );

    img_loader u_loader (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (ld_start),
        .i_in_valid (i_in_valid),
        .i_in_data  (i_in_data),
        .o_in_ready (o_in_ready),
        .o_req      (ld_req),
        .o_done     (ld_done)
    );

    view_ctrl u_view (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_op_valid (i_op_valid),
        .i_op_mode  (i_op_mode),
        .i_idle     (idle),
        .o_view     (view)
    );

    display_stream u_display (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (ds_start),
        .i_view  (view),
        .i_rdata (rdata),
        .o_req   (ds_req),
        .o_pix   (ds_pix),
        .o_done  (ds_done)
    );

    gauss_conv u_conv (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (gc_start),
        .i_view  (view),
        .i_rdata (rdata),
        .o_req   (gc_req),
        .o_pix   (gc_pix),
        .o_done  (gc_done)
    );

endmodule

`default_nettype wire

// File: include/tb_img_model.svh
`ifndef TB_IMG_MODEL_SVH
`define TB_IMG_MODEL_SVH

// reference image by raster index c*64 + y*8 + x
logic [7:0] ref_img [2048];

// expected view state
int ref_ox;
int ref_oy;
int ref_depth;

// neighbours outside the 8x8 plane read as zero
function automatic int pixel_at(input int c, input int x, input int y);
    if (x < 0 || x > 7 || y < 0 || y > 7) begin
        return 0;
    end
    return ref_img[c * 64 + y * 8 + x];
endfunction

// saturating origin moves, depth steps 8 / 16 / 32
task automatic apply_view_op(input logic [3:0] mode);
    case (mode)
        img_core_pkg::OP_ORG_R:   ref_ox = (ref_ox < 6) ? ref_ox + 1 : ref_ox;
        img_core_pkg::OP_ORG_L:   ref_ox = (ref_ox > 0) ? ref_ox - 1 : ref_ox;
        img_core_pkg::OP_ORG_U:   ref_oy = (ref_oy > 0) ? ref_oy - 1 : ref_oy;
        img_core_pkg::OP_ORG_D:   ref_oy = (ref_oy < 6) ? ref_oy + 1 : ref_oy;
        img_core_pkg::OP_SCALE_D: ref_depth = (ref_depth > 8) ? ref_depth / 2 : ref_depth;
        img_core_pkg::OP_SCALE_U: ref_depth = (ref_depth < 32) ? ref_depth * 2 : ref_depth;
        default: ;
    endcase
endtask

// k-th display value, channel major then the 2x2 position
function automatic int window_pixel(input int k);
    int pos;
    pos = k % 4;
    return pixel_at(k / 4, ref_ox + pos % 2, ref_oy + pos / 2);
endfunction

// gaussian 1 2 1 / 2 4 2 / 1 2 1 over active channels, then rounded
function automatic int conv_expect(input int pos);
    int px;
    int py;
    int sum;
    int w;
    px  = ref_ox + pos % 2;
    py  = ref_oy + pos / 2;
    sum = 0;
    for (int c = 0; c < ref_depth; c++) begin
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                // centre row and column weigh double
                w   = ((dx == 0) ? 2 : 1) * ((dy == 0) ? 2 : 1);
                sum = sum + w * pixel_at(c, px + dx, py + dy);
            end
        end
    end
    return (sum + 8) / 16;
endfunction

`endif

// File: test/tb_img_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_img_core;

    // starts low without an edge at time zero
    logic        i_clk = 1'b0;
    logic        i_rst_n;
    logic        i_op_valid;
    logic [3:0]  i_op_mode;
    logic        i_in_valid;
    logic [7:0]  i_in_data;
    logic        o_op_ready;
    logic        o_in_ready;
    logic        o_out_valid;
    logic signed [13:0] o_out_data;

    integer seed;
    // high while an output burst is expected
    logic   out_window;
    // o_op_ready as seen on the previous falling edge
    logic   ready_seen;

    `include "tb_img_model.svh"

    img_core u_img_core (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (i_op_mode),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .o_op_ready  (o_op_ready),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    initial begin
        forever #10 i_clk = ~i_clk;
    end

    // --------------------------------------------------
    // error reporting
    // --------------------------------------------------
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    endtask

    task automatic event_error(input string what);
        $display("[ERROR] %s", what);
        abort_run();
    endtask

    // outputs quiet in reset and no stray output valid afterwards
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            assert (o_op_ready === 1'b0) else value_error("o_op_ready", o_op_ready, 0);
            assert (o_in_ready === 1'b0) else value_error("o_in_ready", o_in_ready, 0);
            assert (o_out_valid === 1'b0) else value_error("o_out_valid", o_out_valid, 0);
        end else if (!out_window) begin
            assert (o_out_valid === 1'b0) else value_error("o_out_valid", o_out_valid, 0);
        end
        // ready is a single cycle pulse
        if (i_rst_n && ready_seen) begin
            assert (o_op_ready === 1'b0) else value_error("o_op_ready", o_op_ready, 0);
        end
        ready_seen = (o_op_ready === 1'b1);
    end

    // --------------------------------------------------
    // bounded waits sampled on the falling edge
    // --------------------------------------------------
    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (o_op_ready !== 1'b1) begin
            if (n >= limit) begin
                event_error("timed out waiting for o_op_ready");
            end else begin
                @(negedge i_clk);
                n++;
            end
        end
    endtask

    task automatic wait_out_valid(input int limit);
        int n;
        n = 0;
        while (o_out_valid !== 1'b1) begin
            if (n >= limit) begin
                event_error("timed out waiting for o_out_valid");
            end else begin
                @(negedge i_clk);
                n++;
            end
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    // one strobe in an idle cycle and back low in the cycle after
    task automatic send_op(input logic [3:0] mode);
        @(negedge i_clk);
        i_op_valid = 1'b1;
        i_op_mode  = mode;
        @(negedge i_clk);
        i_op_valid = 1'b0;
    endtask

    // view and ignored ops pulse ready in the next cycle only
    task automatic view_op(input logic [3:0] mode);
        send_op(mode);
        apply_view_op(mode);
        assert (o_op_ready === 1'b1) else value_error("o_op_ready", o_op_ready, 1);
        @(negedge i_clk);
        assert (o_op_ready === 1'b0) else value_error("o_op_ready", o_op_ready, 0);
    endtask

    task automatic load_image();
        int k;
        logic gap;
        send_op(img_core_pkg::OP_LOAD);
        k = 0;
        while (k < 2048) begin
            assert (o_in_ready === 1'b1) else value_error("o_in_ready", o_in_ready, 1);
            assert (o_op_ready === 1'b0) else value_error("o_op_ready", o_op_ready, 0);
            // idle cycles now and then between bytes
            gap = (($random(seed) & 3) == 0);
            i_in_valid = !gap;
            if (!gap) begin
                i_in_data  = $random(seed);
                ref_img[k] = i_in_data;
                k++;
            end
            @(negedge i_clk);
        end
        i_in_valid = 1'b0;
        assert (o_in_ready === 1'b0) else value_error("o_in_ready", o_in_ready, 0);
        wait_ready(4);
        assert (o_in_ready === 1'b0) else value_error("o_in_ready", o_in_ready, 0);
    endtask

    // unbroken burst of 4 x depth pixels
    task automatic run_display();
        int total;
        int k;
        logic [13:0] exp_data;
        total      = 4 * ref_depth;
        out_window = 1'b1;
        send_op(img_core_pkg::OP_DISPLAY);
        wait_out_valid(16);
        for (k = 0; k < total; k++) begin
            exp_data = window_pixel(k);
            assert (o_out_valid === 1'b1) else value_error("o_out_valid", o_out_valid, 1);
            assert (o_out_data === exp_data) else value_error("o_out_data", o_out_data, exp_data);
            @(negedge i_clk);
        end
        assert (o_out_valid === 1'b0) else value_error("o_out_valid", o_out_valid, 0);
        assert (o_op_ready === 1'b1) else value_error("o_op_ready", o_op_ready, 1);
        out_window = 1'b0;
    endtask

    // four single cycle results in window order
    task automatic run_conv();
        int p;
        logic [13:0] exp_data;
        out_window = 1'b1;
        send_op(img_core_pkg::OP_CONV);
        for (p = 0; p < 4; p++) begin
            wait_out_valid(9 * ref_depth + 16);
            exp_data = conv_expect(p);
            assert (o_out_data === exp_data) else value_error("o_out_data", o_out_data, exp_data);
            @(negedge i_clk);
            assert (o_out_valid === 1'b0) else value_error("o_out_valid", o_out_valid, 0);
        end
        assert (o_op_ready === 1'b1) else value_error("o_op_ready", o_op_ready, 1);
        out_window = 1'b0;
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        seed       = 76;
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = 4'd0;
        i_in_valid = 1'b0;
        i_in_data  = 8'd0;
        out_window = 1'b0;
        ready_seen = 1'b0;
        ref_ox     = 0;
        ref_oy     = 0;
        ref_depth  = 32;
        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;
        wait_ready(3);

        load_image();
        run_display();

        // saturate origin at 6,6 and depth at 8
        repeat (8) view_op(img_core_pkg::OP_ORG_R);
        repeat (8) view_op(img_core_pkg::OP_ORG_D);
        repeat (3) view_op(img_core_pkg::OP_SCALE_D);
        run_display();
        run_conv();

        // back to the corner at depth 16
        repeat (6) view_op(img_core_pkg::OP_ORG_L);
        repeat (6) view_op(img_core_pkg::OP_ORG_U);
        view_op(img_core_pkg::OP_SCALE_U);
        run_conv();

        // dropped and undefined codes leave the view alone
        view_op(4'd9);
        view_op(4'd10);
        view_op(4'd15);
        run_display();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: img_core.f
+incdir+include
src/img_core_pkg.sv
src/img_bank_mem.sv
src/img_loader.sv
src/view_ctrl.sv
src/display_stream.sv
src/gauss_conv.sv
src/img_core.sv
test/tb_img_core.sv

// File: Bender.yml
package:
  name: img_core

sources:
  - files:
      - src/img_core_pkg.sv
      - src/img_bank_mem.sv
      - src/img_loader.sv
      - src/view_ctrl.sv
      - src/display_stream.sv
      - src/gauss_conv.sv
      - src/img_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_img_core.sv
